// File: include/frontend_config.svh
`ifndef FRONTEND_CONFIG_SVH
`define FRONTEND_CONFIG_SVH

// Frontend queue depth. The issuer starts with the same number of credits.
`define FRONTQ_DEPTH 8

// Queue pointer width, log2 of the depth.
`define FRONTQ_PTR_W 3

// Width of the credit counter and the queue occupancy count.
// One bit wider than the pointer so a full queue can be represented.
`define CREDIT_W 4

// First fetch address after reset.
`define RESET_PC 32'h0000_1000

// Sequential fetch step, one 32-bit instruction per slot.
`define PC_STEP 32'd4

`endif

// File: list.f
+incdir+include
rtl/frontend_pkg.sv
rtl/pipe_enable_gen.sv
rtl/fetch_issuer.sv
rtl/fetch_meta_pipe.sv
rtl/packet_pairer.sv
rtl/frontq.sv
rtl/frontend_top.sv
testbench/frontend_tb.sv

// File: rtl/fetch_issuer.sv
`timescale 1ns/1ps
`default_nettype none

`include "frontend_config.svh"

module fetch_issuer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pipe_en,
    input  frontend_pkg::redirect_t  branch,
    input  frontend_pkg::redirect_t  replay,
    input  logic                     replay_credit,
    input  logic                     pop_credit,
    output frontend_pkg::fetch_req_t req,
    output logic                     req_valid,
    output frontend_pkg::slot_meta_t issue_meta
);

    localparam logic [`CREDIT_W-1:0] CREDIT_MAX = `CREDIT_W'(`FRONTQ_DEPTH);

    logic [31:0]          pc;
    logic [31:0]          slot_id;
    logic [`CREDIT_W-1:0] credits;
    logic                 running;
    logic                 redirect;
    logic [31:0]          redirect_pc;

    // A branch always wins over a replay from stage b.
    assign redirect    = branch.valid || replay.valid;
    assign redirect_pc = branch.valid ? branch.target : replay.target;

    // No request goes out in a redirect cycle. The slots that are still in
    // flight are either flushed or dropped by the replay suppression window.
    assign req_valid = pipe_en && running && (credits != '0) && !redirect;

    assign req.addr = pc;
    assign req.tag  = slot_id;

    // Acceptance is filled in by the meta pipe once memory has answered.
    assign issue_meta.live     = req_valid;
    assign issue_meta.accepted = 1'b0;
    assign issue_meta.pc       = pc;
    assign issue_meta.slot     = slot_id;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc      <= `RESET_PC;
            slot_id <= '0;
            credits <= CREDIT_MAX;
            running <= 1'b0;
        end else if (pipe_en) begin
            running <= 1'b1;
            if (redirect) begin
                pc <= redirect_pc;
            end else if (req_valid) begin
                pc <= pc + `PC_STEP;
            end
            // Slot ids never restart, so a stale response can't alias a new slot.
            if (req_valid) begin
                slot_id <= slot_id + 32'd1;
            end
            // A branch empties the pipe and the queue, so every credit is home.
            if (branch.valid) begin
                credits <= CREDIT_MAX;
            end else begin
                credits <= credits - `CREDIT_W'(req_valid)
                           + `CREDIT_W'(replay_credit) + `CREDIT_W'(pop_credit);
            end
        end
    end

    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= CREDIT_MAX);

endmodule

`default_nettype wire

// File: rtl/fetch_meta_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_meta_pipe (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pipe_en,
    input  logic                     flush,
    input  frontend_pkg::slot_meta_t issue_meta,
    input  logic                     mem_accept,
    output frontend_pkg::slot_meta_t stage_b
);

    import frontend_pkg::*;

    slot_meta_t stage_a;

    // Two stages, so stage b lines up with the memory response of the same slot.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_a <= '0;
            stage_b <= '0;
        end else if (pipe_en) begin
            if (flush) begin
                // Only the live bits matter here. The payload is left as it is.
                stage_a.live <= 1'b0;
                stage_b.live <= 1'b0;
            end else begin
                stage_a.live     <= issue_meta.live;
                stage_a.accepted <= issue_meta.live && mem_accept;
                stage_a.pc       <= issue_meta.pc;
                stage_a.slot     <= issue_meta.slot;
                stage_b          <= stage_a;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/frontend_pkg.sv
`default_nettype none

package frontend_pkg;

    // Fetch request sent to the instruction memory.
    // The tag carries the slot id so the response can be paired later.
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] tag;
    } fetch_req_t;

    // Response from memory, two enabled cycles after its request.
    typedef struct packed {
        logic [31:0] data;
        logic [31:0] tag;
    } fetch_resp_t;

    // Metadata of one slot while it travels beside the memory access.
    // live marks a real request, accepted records whether memory took it.
    typedef struct packed {
        logic        live;
        logic        accepted;
        logic [31:0] pc;
        logic [31:0] slot;
    } slot_meta_t;

    // Paired packet as seen by the decoder.
    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] slot;
    } front_pkt_t;

    // Fetch redirect, used for branches and for replays.
    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

    // Outcome for the slot at stage b.
    typedef enum logic [1:0] {
        PAIR_IDLE   = 2'd0,
        PAIR_PUSH   = 2'd1,
        PAIR_REPLAY = 2'd2
    } pair_action_e;

endpackage

`default_nettype wire

// File: rtl/frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [31:0]               clock_divider,
    output frontend_pkg::fetch_req_t  req,
    output logic                      req_valid,
    input  logic                      mem_accept,
    input  frontend_pkg::fetch_resp_t resp,
    input  logic                      mem_stall,
    output frontend_pkg::front_pkt_t  pkt,
    output logic                      pkt_valid,
    input  logic                      pkt_pop,
    input  frontend_pkg::redirect_t   branch,
    output logic                      pipe_en
);

    import frontend_pkg::*;

    slot_meta_t issue_meta;
    slot_meta_t stage_b;
    front_pkt_t push;
    logic       push_valid;
    redirect_t  replay;
    logic       replay_credit;
    logic       pop_credit;

    pipe_enable_gen i_enable (
        .clk           (clk),
        .rst_n         (rst_n),
        .clock_divider (clock_divider),
        .mem_stall     (mem_stall),
        .pipe_en       (pipe_en)
    );

    fetch_issuer i_issuer (
        .clk           (clk),
        .rst_n         (rst_n),
        .pipe_en       (pipe_en),
        .branch        (branch),
        .replay        (replay),
        .replay_credit (replay_credit),
        .pop_credit    (pop_credit),
        .req           (req),
        .req_valid     (req_valid),
        .issue_meta    (issue_meta)
    );

    // The memory access itself runs outside, in parallel with this pipe.
    fetch_meta_pipe i_meta (
        .clk        (clk),
        .rst_n      (rst_n),
        .pipe_en    (pipe_en),
        .flush      (branch.valid),
        .issue_meta (issue_meta),
        .mem_accept (mem_accept),
        .stage_b    (stage_b)
    );

    packet_pairer i_pairer (
        .clk           (clk),
        .rst_n         (rst_n),
        .pipe_en       (pipe_en),
        .flush         (branch.valid),
        .stage_b       (stage_b),
        .resp          (resp),
        .push          (push),
        .push_valid    (push_valid),
        .replay        (replay),
        .replay_credit (replay_credit)
    );

    frontq i_frontq (
        .clk        (clk),
        .rst_n      (rst_n),
        .pipe_en    (pipe_en),
        .flush      (branch.valid),
        .push       (push),
        .push_valid (push_valid),
        .pkt_pop    (pkt_pop),
        .pkt        (pkt),
        .pkt_valid  (pkt_valid),
        .pop_credit (pop_credit)
    );

endmodule

`default_nettype wire

// File: rtl/frontq.sv
`timescale 1ns/1ps
`default_nettype none

`include "frontend_config.svh"

module frontq (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pipe_en,
    input  logic                     flush,
    input  frontend_pkg::front_pkt_t push,
    input  logic                     push_valid,
    input  logic                     pkt_pop,
    output frontend_pkg::front_pkt_t pkt,
    output logic                     pkt_valid,
    output logic                     pop_credit
);

    import frontend_pkg::*;

    localparam logic [`CREDIT_W-1:0] DEPTH = `CREDIT_W'(`FRONTQ_DEPTH);

    front_pkt_t               entries [`FRONTQ_DEPTH];
    logic [`FRONTQ_PTR_W-1:0] rptr;
    logic [`FRONTQ_PTR_W-1:0] wptr;
    logic [`CREDIT_W-1:0]     count;
    logic                     full;
    logic                     do_push;
    logic                     do_pop;

    assign full      = (count == DEPTH);
    assign pkt_valid = (count != '0);
    assign pkt       = entries[rptr];

    // A flush drops everything, so neither a push nor a pop counts then.
    assign do_push = pipe_en && push_valid && !flush;
    assign do_pop  = pipe_en && pkt_pop && pkt_valid && !flush;

    // Every packet leaving the queue frees one issue credit.
    assign pop_credit = do_pop;

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wptr] <= push;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rptr  <= '0;
            wptr  <= '0;
            count <= '0;
        end else if (pipe_en) begin
            if (flush) begin
                rptr  <= '0;
                wptr  <= '0;
                count <= '0;
            end else begin
                if (do_push) begin
                    wptr <= wptr + 1'b1;
                end
                if (do_pop) begin
                    rptr <= rptr + 1'b1;
                end
                case ({do_push, do_pop})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end
    end

    // The issuer only spends a credit it holds, so a full queue never sees
    // a push unless the decoder frees an entry in the same cycle.
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        (pipe_en && push_valid && !flush && full) |-> do_pop);

endmodule

`default_nettype wire

// File: rtl/packet_pairer.sv
`timescale 1ns/1ps
`default_nettype none

module packet_pairer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      pipe_en,
    input  logic                      flush,
    input  frontend_pkg::slot_meta_t  stage_b,
    input  frontend_pkg::fetch_resp_t resp,
    output frontend_pkg::front_pkt_t  push,
    output logic                      push_valid,
    output frontend_pkg::redirect_t   replay,
    output logic                      replay_credit
);

    import frontend_pkg::*;

    localparam logic [1:0] SUPPRESS_CYCLES = 2'd2;

    pair_action_e action;
    logic [1:0]   suppress_cnt;
    logic         suppressed;
    logic         tag_match;
    logic         dropped;

    assign suppressed = (suppress_cnt != 2'd0);

    // The tag is the only reliable proof that this response belongs to the slot.
    assign tag_match = stage_b.accepted && (resp.tag == stage_b.slot);

    always_comb begin
        action = PAIR_IDLE;
        if (stage_b.live && !flush && !suppressed) begin
            if (tag_match) begin
                action = PAIR_PUSH;
            end else begin
                action = PAIR_REPLAY;
            end
        end
    end

    // Slots reaching stage b right after a replay are younger than the
    // replayed one and must not be queued. They only give back their credit.
    assign dropped = stage_b.live && !flush && suppressed;

    assign push       = '{instr: resp.data, pc: stage_b.pc, slot: stage_b.slot};
    assign push_valid = (action == PAIR_PUSH);

    assign replay.valid  = (action == PAIR_REPLAY);
    assign replay.target = stage_b.pc;

    assign replay_credit = (action == PAIR_REPLAY) || dropped;

    // The window keeps counting across a flush, since old responses may
    // still be on their way.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            suppress_cnt <= 2'd0;
        end else if (pipe_en) begin
            if (replay.valid) begin
                suppress_cnt <= SUPPRESS_CYCLES;
            end else if (suppressed) begin
                suppress_cnt <= suppress_cnt - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/pipe_enable_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_enable_gen (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] clock_divider,
    input  logic        mem_stall,
    output logic        pipe_en
);

    logic [31:0] div_count;
    logic        div_en;

    // A divider of N gives one enabled clock in every N+1 base clocks.
    // Zero runs the pipeline on every clock.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_count <= '0;
            div_en    <= 1'b0;
        end else if (clock_divider == 32'd0) begin
            div_count <= '0;
            div_en    <= 1'b1;
        end else if (div_count >= clock_divider) begin
            div_count <= '0;
            div_en    <= 1'b1;
        end else begin
            div_count <= div_count + 32'd1;
            div_en    <= 1'b0;
        end
    end

    // The divider keeps running during a memory stall, only the enable is held off.
    assign pipe_en = div_en && !mem_stall;

    // With a nonzero divider two enabled clocks are never back to back.
    a_divided_gap: assert property (@(posedge clk) disable iff (!rst_n)
        (pipe_en && clock_divider != 32'd0) |=> !pipe_en);

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module frontend_tb \
    -f list.f --Mdir obj_dir -o frontend_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/frontend_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0

// File: include/frontend_tb_tasks.svh
`ifndef FRONTEND_TB_TASKS_SVH
`define FRONTEND_TB_TASKS_SVH

task automatic compare_pkt(input string name, input front_pkt_t expected,
                           input front_pkt_t actual);
    if (expected !== actual) begin
        $display("Error: %s expected %h actual %h", name, expected, actual);
        $display("CHECKS FAILED");
        $fatal(1, "packet mismatch");
    end
endtask

task automatic compare_bit(input string name, input logic expected, input logic actual);
    if (expected !== actual) begin
        $display("Error: %s expected %b actual %b", name, expected, actual);
        $display("CHECKS FAILED");
        $fatal(1, "bit mismatch");
    end
endtask

task automatic compare_count(input string name, input int unsigned expected,
                             input int unsigned actual);
    if (expected != actual) begin
        $display("Error: %s expected %0d actual %0d", name, expected, actual);
        $display("CHECKS FAILED");
        $fatal(1, "count mismatch");
    end
endtask

// Holds the branch until an enabled edge has taken it, then marks where the new stream starts.
task automatic redirect_to(input logic [31:0] target);
    @(negedge clk);
    branch = '{valid: 1'b1, target: target};
    #1;
    while (!pipe_en) begin
        @(negedge clk);
        #1;
    end
    @(negedge clk);
    branch = '0;
    stream_base = popped.size();
    accept_base = accepted_cnt;
endtask

// Packets must follow the PC step from first_pc and carry the tag of the accepted request.
task automatic check_stream(input string name, input logic [31:0] first_pc, input int count);
    front_pkt_t  expected;
    logic [31:0] pc;
    while (popped.size() < stream_base + count) begin
        @(negedge clk);
    end
    for (int i = 0; i < count; i++) begin
        pc = first_pc + 32'(i) * `PC_STEP;
        expected.instr = pc ^ DATA_MASK;
        expected.pc    = pc;
        expected.slot  = tag_of_pc.exists(pc) ? tag_of_pc[pc] : 32'hxxxx_xxxx;
        compare_pkt(name, expected, popped[stream_base + i]);
    end
endtask

task automatic run_in_order_stream();
    @(negedge clk);
    pkt_pop = 1'b1;
    check_stream("in_order_stream", `RESET_PC, 20);
endtask

task automatic run_replay();
    redirect_to(32'h0000_4000);
    refuse_random = 1'b1;
    check_stream("replay", 32'h0000_4000, 24);
    refuse_random = 1'b0;
    compare_bit("replay refusals seen", 1'b1, refused_cnt != 0);
endtask

task automatic run_back_pressure();
    @(negedge clk);
    pkt_pop = 1'b0;
    redirect_to(32'h0000_8000);
    while (accepted_cnt - accept_base < `FRONTQ_DEPTH) begin
        @(negedge clk);
    end
    // All credits are spent, so no request may go out until the decoder pops.
    repeat (20) begin
        @(negedge clk);
        #1;
        compare_bit("back_pressure req_valid", 1'b0, req_valid);
    end
    compare_count("back_pressure accepted", `FRONTQ_DEPTH, accepted_cnt - accept_base);
    @(negedge clk);
    pkt_pop = 1'b1;
    check_stream("back_pressure", 32'h0000_8000, `FRONTQ_DEPTH);
endtask

task automatic run_branch();
    // Let slots pile up in flight so the branch has something to flush.
    repeat (6) begin
        @(negedge clk);
    end
    redirect_to(32'h0002_0040);
    check_stream("branch", 32'h0002_0040, 16);
endtask

task automatic run_divider();
    front_pkt_t held_pkt;
    logic       held_valid;
    redirect_to(32'h0000_c000);
    clock_divider = 32'd2;
    do begin
        @(negedge clk);
        #1;
    end while (!pipe_en);
    for (int i = 0; i < 9; i++) begin
        compare_bit("divider pipe_en", (i % 3) == 0, pipe_en);
        @(negedge clk);
        #1;
    end
    @(negedge clk);
    mem_stall = 1'b1;
    held_pkt = pkt;
    held_valid = pkt_valid;
    // The queue head must stay frozen while memory stalls the pipeline.
    repeat (12) begin
        @(negedge clk);
        #1;
        compare_bit("stall pipe_en", 1'b0, pipe_en);
        compare_bit("stall pkt_valid", held_valid, pkt_valid);
        compare_pkt("stall pkt", held_pkt, pkt);
    end
    @(negedge clk);
    mem_stall = 1'b0;
    clock_divider = 32'd0;
    check_stream("divider", 32'h0000_c000, 12);
endtask

`endif

// File: testbench/frontend_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "frontend_config.svh"

module frontend_tb;

    import frontend_pkg::*;

    localparam int          NUM_TESTS       = 5;
    localparam int          CYCLES_PER_TEST = 400;
    localparam logic [31:0] DATA_MASK       = 32'hA5A5_0000;

    // One enabled cycle of the request port as the memory saw it.
    typedef struct packed {
        logic       taken;
        fetch_req_t req;
    } mem_slot_t;

    logic        clk;
    logic        rst_n;
    logic [31:0] clock_divider;
    fetch_req_t  req;
    logic        req_valid;
    logic        mem_accept = 1'b1;
    fetch_resp_t resp = '0;
    logic        mem_stall;
    front_pkt_t  pkt;
    logic        pkt_valid;
    logic        pkt_pop;
    redirect_t   branch;
    logic        pipe_en;

    mem_slot_t   mem_q [2] = '{default: '0};
    mem_slot_t   last_slot = '0;
    logic        last_en = 1'b0;
    logic        refuse_random;
    int unsigned issued_cnt = 0;
    int unsigned accepted_cnt = 0;
    int unsigned refused_cnt = 0;
    int unsigned accept_base;
    int unsigned stream_base;
    front_pkt_t  popped [$];
    logic [31:0] tag_of_pc [logic [31:0]];

    frontend_top i_dut (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // The memory runs in the low half of the clock, after the tests have driven.
    // A response moves one step per enabled edge, so it lines up with stage b.
    always @(negedge clk) begin
        #2;
        if (last_en) begin
            mem_q[1] = mem_q[0];
            mem_q[0] = last_slot;
        end
        resp.data = mem_q[1].req.addr ^ DATA_MASK;
        // A refused request comes back with a tag that belongs to no slot.
        resp.tag = mem_q[1].taken ? mem_q[1].req.tag : ~mem_q[1].req.tag;
        mem_accept = refuse_random ? (($urandom % 4) != 0) : 1'b1;
        #1;
        last_en = pipe_en;
        last_slot.taken = req_valid && mem_accept;
        last_slot.req = req;
        if (req_valid) begin
            // Slot ids start at zero after reset and count every issued request.
            compare_count("request tag", issued_cnt, req.tag);
            if (mem_accept) begin
                accepted_cnt++;
                tag_of_pc[req.addr] = issued_cnt;
            end else begin
                refused_cnt++;
            end
            issued_cnt++;
        end
        // The decoder takes a packet on an enabled edge, unless a branch flushes it.
        if (pipe_en && pkt_pop && pkt_valid && !branch.valid) begin
            popped.push_back(pkt);
        end
    end

    `include "frontend_tb_tasks.svh"

    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) begin
            @(posedge clk);
        end
        $display("Timeout: the tests did not finish within %0d cycles",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(7665));
        rst_n = 1'b0;
        clock_divider = 32'd0;
        mem_stall = 1'b0;
        pkt_pop = 1'b0;
        branch = '0;
        refuse_random = 1'b0;
        accept_base = 0;
        stream_base = 0;
        repeat (3) begin
            @(posedge clk);
        end
        @(negedge clk);
        rst_n = 1'b1;
        run_in_order_stream();
        run_replay();
        run_back_pressure();
        run_branch();
        run_divider();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
